//--- design/snes_bus_pkg.sv
package snes_bus_pkg;

  localparam int SNES_ADDR_W = 24;
  localparam int SNES_DATA_W = 8;

  // samples kept per console line
  localparam int SYNC_DEPTH = 7;

  // filtered console levels
  // read, write and romsel stay active low like the pins
  typedef struct packed {
    logic                   read;
    logic                   write;
    logic                   cpu_clk;
    logic                   romsel;
    logic [SNES_ADDR_W-1:0] addr;
    logic [SNES_DATA_W-1:0] data;
  } snes_bus_t;

  // single-cycle strobes
  typedef struct packed {
    logic rd_start;
    logic rd_end;
    logic wr_end;
    logic cycle_start;
    logic cycle_end;
    logic revive;
  } snes_events_t;

endpackage

//--- design/mem_pkg.sv
package mem_pkg;

  localparam int ROM_ADDR_W = 23;
  localparam int ROM_DATA_W = 16;
  localparam int RAM_ADDR_W = 19;

  // delay counter loads, address phase is one cycle longer
  localparam logic [3:0] ROM_CYCLE_LEN = 4'd7;
  localparam logic [3:0] RAM_CYCLE_LEN = 4'd5;

  // 880000-8FFFFF goes to the SRAM
  localparam logic [4:0] RAM_REGION = 5'b10001;

  typedef logic [7:0] byte_t;

  // one MCU address seen as PSRAM word+lane or as SRAM region+offset
  typedef union packed {
    struct packed {
      logic [ROM_ADDR_W-1:0] word;
      logic                  byte_sel;
    } rom;
    struct packed {
      logic [4:0]            region;
      logic [RAM_ADDR_W-1:0] offset;
    } ram;
  } mcu_addr_u;

  typedef struct packed {
    logic      rd;
    logic      wr;
    mcu_addr_u addr;
    byte_t     wdata;
  } mcu_req_t;

  typedef struct packed {
    logic  done;
    logic  was_read;
    byte_t rdata;
  } mem_done_t;

  typedef struct packed {
    logic [ROM_ADDR_W-1:0] addr;
    logic [ROM_DATA_W-1:0] wdata;
    logic                  we_n;
    logic                  bhe_n;
    logic                  ble_n;
  } rom_port_t;

  typedef struct packed {
    logic [RAM_ADDR_W-1:0] addr;
    byte_t                 wdata;
    logic                  we_n;
  } ram_port_t;

endpackage

//--- design/snes_bus_sync.sv
module snes_bus_sync #(
  parameter int dead_timeout = 84000
) (
  input  logic                                 rst_n,
  input  logic                                 CLK2,
  input  logic [snes_bus_pkg::SNES_ADDR_W-1:0] snes_addr_in,
  input  mem_pkg::byte_t                       snes_data_in,
  input  logic                                 snes_read_n,
  input  logic                                 snes_write_n,
  input  logic                                 snes_cpu_clk,
  input  logic                                 snes_romsel_n,
  output snes_bus_pkg::snes_bus_t              bus,
  output snes_bus_pkg::snes_events_t           events,
  output logic                                 snes_dead
);

  logic [snes_bus_pkg::SYNC_DEPTH-1:0]  read_sr;
  logic [snes_bus_pkg::SYNC_DEPTH-1:0]  write_sr;
  logic [snes_bus_pkg::SYNC_DEPTH-1:0]  cpu_clk_sr;
  logic [snes_bus_pkg::SYNC_DEPTH-1:0]  romsel_sr;
  logic [snes_bus_pkg::SNES_ADDR_W-1:0] addr_sr [snes_bus_pkg::SYNC_DEPTH];
  mem_pkg::byte_t                       data_sr [snes_bus_pkg::SYNC_DEPTH];
  logic [$clog2(dead_timeout + 3)-1:0]  dead_cnt;
  logic                                 revive;

  // -------------------------------------------------------------------------
  // oversampling
  // -------------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      read_sr    <= '1;
      write_sr   <= '1;
      cpu_clk_sr <= '0;
      romsel_sr  <= '1;
    end else begin
      read_sr    <= {read_sr[snes_bus_pkg::SYNC_DEPTH-2:0], snes_read_n};
      write_sr   <= {write_sr[snes_bus_pkg::SYNC_DEPTH-2:0], snes_write_n};
      cpu_clk_sr <= {cpu_clk_sr[snes_bus_pkg::SYNC_DEPTH-2:0], snes_cpu_clk};
      romsel_sr  <= {romsel_sr[snes_bus_pkg::SYNC_DEPTH-2:0], snes_romsel_n};
    end
  end

  always_ff @(posedge CLK2) begin
    addr_sr[0] <= snes_addr_in;
    data_sr[0] <= snes_data_in;
    for (int i = 1; i < snes_bus_pkg::SYNC_DEPTH; i++) begin
      addr_sr[i] <= addr_sr[i-1];
      data_sr[i] <= data_sr[i-1];
    end
  end

  // levels are the AND of two neighbouring samples
  assign bus.read    = read_sr[2] & read_sr[1];
  assign bus.write   = write_sr[2] & write_sr[1];
  assign bus.cpu_clk = cpu_clk_sr[2] & cpu_clk_sr[1];
  assign bus.romsel  = romsel_sr[5] & romsel_sr[4];
  assign bus.addr    = addr_sr[6] & addr_sr[5];
  assign bus.data    = data_sr[6] & data_sr[5];

  // edge fires once the new level has held for five samples
  assign events.rd_start    = read_sr[6:1] == 6'b100000;
  assign events.rd_end      = read_sr[6:1] == 6'b011111;
  assign events.wr_end      = write_sr[6:1] == 6'b011111;
  assign events.cycle_start = cpu_clk_sr[6:1] == 6'b011111;
  assign events.cycle_end   = cpu_clk_sr[6:1] == 6'b100000;
  assign events.revive      = revive;

  // -------------------------------------------------------------------------
  // liveness
  // -------------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b1;
      revive    <= 1'b0;
    end else begin
      revive <= 1'b0;
      if (cpu_clk_sr[1]) begin
        dead_cnt  <= '0;
        snes_dead <= 1'b0;
        // first clock after a dead period
        revive    <= snes_dead;
      end else begin
        if (!snes_dead) begin
          dead_cnt <= dead_cnt + 1'b1;
        end
        if (32'(dead_cnt) > dead_timeout) begin
          snes_dead <= 1'b1;
        end
      end
    end
  end

  a_rd_edges_apart: assert property (@(posedge CLK2) disable iff (!rst_n)
    !(events.rd_start && events.rd_end));

endmodule

//--- design/mcu_req_router.sv
module mcu_req_router (
  input  logic               CLK2,
  input  logic               rst_n,
  input  logic               mcu_rrq,
  input  logic               mcu_wrq,
  input  mem_pkg::mcu_addr_u mcu_addr,
  input  mem_pkg::byte_t     mcu_wdata,
  output mem_pkg::mcu_req_t  rom_req,
  output mem_pkg::mcu_req_t  ram_req,
  input  mem_pkg::mem_done_t rom_done,
  input  mem_pkg::mem_done_t ram_done,
  output logic               mcu_rdy,
  output mem_pkg::byte_t     mcu_rdata
);

  logic is_ram;
  logic rom_busy;
  logic ram_busy;

  // region decode
  assign is_ram = mcu_addr.ram.region == mem_pkg::RAM_REGION;

  assign rom_req = '{rd: mcu_rrq & ~is_ram, wr: mcu_wrq & ~is_ram,
                     addr: mcu_addr, wdata: mcu_wdata};
  assign ram_req = '{rd: mcu_rrq & is_ram, wr: mcu_wrq & is_ram,
                     addr: mcu_addr, wdata: mcu_wdata};

  // busy per target
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      rom_busy <= 1'b0;
      ram_busy <= 1'b0;
    end else begin
      if (rom_req.rd | rom_req.wr) begin
        rom_busy <= 1'b1;
      end else if (rom_done.done) begin
        rom_busy <= 1'b0;
      end
      if (ram_req.rd | ram_req.wr) begin
        ram_busy <= 1'b1;
      end else if (ram_done.done) begin
        ram_busy <= 1'b0;
      end
    end
  end

  assign mcu_rdy = ~rom_busy & ~ram_busy;

  // read data lands together with ready
  always_ff @(posedge CLK2) begin
    if (rom_done.done && rom_done.was_read) begin
      mcu_rdata <= rom_done.rdata;
    end else if (ram_done.done && ram_done.was_read) begin
      mcu_rdata <= ram_done.rdata;
    end
  end

  a_req_only_when_rdy: assert property (@(posedge CLK2) disable iff (!rst_n)
    (mcu_rrq || mcu_wrq) |-> mcu_rdy);

  a_req_one_kind: assert property (@(posedge CLK2) disable iff (!rst_n)
    !(mcu_rrq && mcu_wrq));

endmodule

//--- design/rom_sequencer.sv
module rom_sequencer (
  input  logic                           CLK2,
  input  logic                           rst_n,
  input  mem_pkg::mcu_req_t              req,
  input  logic                           revive,
  input  logic [mem_pkg::ROM_DATA_W-1:0] rom_rdata,
  output mem_pkg::rom_port_t             rom,
  output mem_pkg::mem_done_t             done
);

  enum logic [1:0] {ST_IDLE, ST_ADDR, ST_END} state;

  logic               rd_pend;
  logic               wr_pend;
  logic [3:0]         delay;
  mem_pkg::mcu_addr_u addr_r;
  mem_pkg::byte_t     wdata_r;
  mem_pkg::byte_t     rdata_r;
  logic               lane_lo;
  logic               active;

  // odd addresses xxx1 sit on the low lane
  assign lane_lo = addr_r.rom.byte_sel;
  assign active  = state != ST_IDLE;

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
    end else if (req.rd) begin
      rd_pend <= 1'b1;
    end else if (req.wr) begin
      wr_pend <= 1'b1;
    end else if (state == ST_END) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
    end
  end

  always_ff @(posedge CLK2) begin
    if (req.rd | req.wr) begin
      addr_r  <= req.addr;
      wdata_r <= req.wdata;
    end
  end

  // revive restarts a pending access from idle
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      delay <= '0;
    end else if (revive) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (rd_pend | wr_pend) begin
            state <= ST_ADDR;
            delay <= mem_pkg::ROM_CYCLE_LEN;
          end
        end
        ST_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= ST_END;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // last sample of the address phase is the one returned
  always_ff @(posedge CLK2) begin
    if (state == ST_ADDR) begin
      rdata_r <= lane_lo ? rom_rdata[7:0] : rom_rdata[15:8];
    end
  end

  always_comb begin
    rom.addr  = addr_r.rom.word;
    rom.wdata = lane_lo ? {8'h00, wdata_r} : {wdata_r, 8'h00};
    rom.we_n  = ~(state == ST_ADDR && wr_pend);
    rom.bhe_n = ~(active & ~lane_lo);
    rom.ble_n = ~(active & lane_lo);
  end

  assign done = '{done: state == ST_END, was_read: rd_pend, rdata: rdata_r};

  // write strobe only in the write address phase, address steady meanwhile
  a_we_in_write_addr: assert property (@(posedge CLK2) disable iff (!rst_n)
    !rom.we_n |-> state == ST_ADDR && wr_pend && $stable(rom.addr));

endmodule

//--- design/ram_port_arbiter.sv
module ram_port_arbiter (
  input  logic                       CLK2,
  input  logic                       rst_n,
  input  mem_pkg::mcu_req_t          req,
  input  snes_bus_pkg::snes_bus_t    bus,
  input  snes_bus_pkg::snes_events_t events,
  input  logic                       snes_dead,
  input  mem_pkg::byte_t             ram_rdata,
  output mem_pkg::ram_port_t         ram,
  output mem_pkg::mem_done_t         done,
  output mem_pkg::byte_t             snes_data_out,
  output logic                       snes_databus_oe_n,
  output logic                       snes_databus_dir
);

  enum logic [1:0] {ST_IDLE, ST_ADDR, ST_END} state;

  logic               rd_pend;
  logic               wr_pend;
  logic [3:0]         delay;
  mem_pkg::mcu_addr_u addr_r;
  mem_pkg::byte_t     wdata_r;
  mem_pkg::byte_t     rdata_r;
  logic               ram_free_strobe;
  logic               free_slot;

  // -------------------------------------------------------------------------
  // free slots
  // -------------------------------------------------------------------------
  // full bandwidth when the cycle is not a ROM access
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      ram_free_strobe <= 1'b0;
    end else begin
      ram_free_strobe <= events.cycle_start & bus.romsel;
    end
  end

  assign free_slot = events.cycle_end | ram_free_strobe | snes_dead;

  // -------------------------------------------------------------------------
  // MCU access
  // -------------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
    end else if (req.rd) begin
      rd_pend <= 1'b1;
    end else if (req.wr) begin
      wr_pend <= 1'b1;
    end else if (state == ST_END) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
    end
  end

  always_ff @(posedge CLK2) begin
    if (req.rd | req.wr) begin
      addr_r  <= req.addr;
      wdata_r <= req.wdata;
    end
  end

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      delay <= '0;
    end else if (events.revive) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (free_slot && (rd_pend || wr_pend)) begin
            state <= ST_ADDR;
            delay <= mem_pkg::RAM_CYCLE_LEN;
          end
        end
        ST_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= ST_END;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK2) begin
    if (state == ST_ADDR) begin
      rdata_r <= ram_rdata;
    end
  end

  assign done = '{done: state == ST_END, was_read: rd_pend, rdata: rdata_r};

  // -------------------------------------------------------------------------
  // SRAM port and console read path
  // -------------------------------------------------------------------------
  // console address whenever the MCU is not on the port
  always_comb begin
    ram.addr  = (state != ST_IDLE) ? addr_r.ram.offset
                                   : bus.addr[mem_pkg::RAM_ADDR_W-1:0];
    ram.wdata = wdata_r;
    ram.we_n  = ~(state == ST_ADDR && wr_pend);
  end

  assign snes_data_out     = ram_rdata;
  assign snes_databus_oe_n = bus.romsel | bus.read;
  // 1 drives towards the console
  assign snes_databus_dir  = ~bus.read;

  a_no_write_on_rom_read: assert property (@(posedge CLK2) disable iff (!rst_n)
    !(!ram.we_n && !bus.romsel && !bus.read));

endmodule

//--- design/snes_mem_ctrl.sv
module snes_mem_ctrl #(
  parameter int dead_timeout = 84000
) (
  input  logic                                 rst_n,
  input  logic                                 CLK2,
  // console
  input  logic [snes_bus_pkg::SNES_ADDR_W-1:0] snes_addr_in,
  input  mem_pkg::byte_t                       snes_data_in,
  input  logic                                 snes_read_n,
  input  logic                                 snes_write_n,
  input  logic                                 snes_cpu_clk,
  input  logic                                 snes_romsel_n,
  output mem_pkg::byte_t                       snes_data_out,
  output logic                                 snes_databus_oe_n,
  output logic                                 snes_databus_dir,
  // MCU
  input  logic                                 mcu_rrq,
  input  logic                                 mcu_wrq,
  input  mem_pkg::mcu_addr_u                   mcu_addr,
  input  mem_pkg::byte_t                       mcu_wdata,
  output logic                                 mcu_rdy,
  output mem_pkg::byte_t                       mcu_rdata,
  // memories
  input  logic [mem_pkg::ROM_DATA_W-1:0]       rom_rdata,
  output mem_pkg::rom_port_t                   rom,
  input  mem_pkg::byte_t                       ram_rdata,
  output mem_pkg::ram_port_t                   ram
);

  snes_bus_pkg::snes_bus_t    bus;
  snes_bus_pkg::snes_events_t events;
  logic                       snes_dead;
  mem_pkg::mcu_req_t          rom_req;
  mem_pkg::mcu_req_t          ram_req;
  mem_pkg::mem_done_t         rom_done;
  mem_pkg::mem_done_t         ram_done;

  // -------------------------------------------------------------------------
  // console sampling
  // -------------------------------------------------------------------------
  snes_bus_sync #(
    .dead_timeout(dead_timeout)
  ) i_snes_bus_sync (
    .rst_n        (rst_n),
    .CLK2         (CLK2),
    .snes_addr_in (snes_addr_in),
    .snes_data_in (snes_data_in),
    .snes_read_n  (snes_read_n),
    .snes_write_n (snes_write_n),
    .snes_cpu_clk (snes_cpu_clk),
    .snes_romsel_n(snes_romsel_n),
    .bus          (bus),
    .events       (events),
    .snes_dead    (snes_dead)
  );

  // -------------------------------------------------------------------------
  // MCU side and memory stages
  // -------------------------------------------------------------------------
  mcu_req_router i_mcu_req_router (
    .CLK2     (CLK2),
    .rst_n    (rst_n),
    .mcu_rrq  (mcu_rrq),
    .mcu_wrq  (mcu_wrq),
    .mcu_addr (mcu_addr),
    .mcu_wdata(mcu_wdata),
    .rom_req  (rom_req),
    .ram_req  (ram_req),
    .rom_done (rom_done),
    .ram_done (ram_done),
    .mcu_rdy  (mcu_rdy),
    .mcu_rdata(mcu_rdata)
  );

  rom_sequencer i_rom_sequencer (
    .CLK2     (CLK2),
    .rst_n    (rst_n),
    .req      (rom_req),
    .revive   (events.revive),
    .rom_rdata(rom_rdata),
    .rom      (rom),
    .done     (rom_done)
  );

  ram_port_arbiter i_ram_port_arbiter (
    .CLK2             (CLK2),
    .rst_n            (rst_n),
    .req              (ram_req),
    .bus              (bus),
    .events           (events),
    .snes_dead        (snes_dead),
    .ram_rdata        (ram_rdata),
    .ram              (ram),
    .done             (ram_done),
    .snes_data_out    (snes_data_out),
    .snes_databus_oe_n(snes_databus_oe_n),
    .snes_databus_dir (snes_databus_dir)
  );

endmodule

//--- verif/tb_snes_mem_ctrl_util.svh
// ---------------------------------------------------------------------------
// counters, random source and reference model
// ---------------------------------------------------------------------------
int value_errors    = 0;
int timeout_errors  = 0;
int protocol_errors = 0;
int reads_checked   = 0;

logic [15:0]    lfsr_state = 16'd54375;
mem_pkg::byte_t shadow [int];

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// one LFSR step per returned bit
function automatic logic [31:0] take_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int k = 0; k < n; k++) begin
    lfsr_state = lfsr_step(lfsr_state);
    v = {v[30:0], lfsr_state[0]};
  end
  return v;
endfunction

// contents of never written memory, every address bit takes part
function automatic logic [15:0] rom_fill(input logic [22:0] word);
  return {word[7:0] ^ word[22:15], word[15:8] ^ 8'h5A};
endfunction

function automatic mem_pkg::byte_t ram_fill(input logic [18:0] offset);
  return offset[7:0] ^ offset[15:8] ^ {5'b0, offset[18:16]} ^ 8'hC3;
endfunction

// expected byte at an MCU address
function automatic mem_pkg::byte_t ref_byte(input mem_pkg::mcu_addr_u a);
  logic [15:0] w;
  if (shadow.exists(int'(a))) begin
    return shadow[int'(a)];
  end
  if (a.ram.region == mem_pkg::RAM_REGION) begin
    return ram_fill(a.ram.offset);
  end
  // odd byte addresses live in the low half of the word
  w = rom_fill(a.rom.word);
  return a.rom.byte_sel ? w[7:0] : w[15:8];
endfunction

// ---------------------------------------------------------------------------
// compare tasks
// ---------------------------------------------------------------------------
task automatic check_byte(input string name, input mem_pkg::byte_t got,
                          input mem_pkg::byte_t exp);
  if (got !== exp) begin
    $display("FAIL %s got %02h expected %02h at %0t", name, got, exp, $time);
    value_errors++;
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
    value_errors++;
  end
endtask

// strobes of both memories inactive
task automatic check_port_idle(input mem_pkg::rom_port_t rp, input mem_pkg::ram_port_t mp);
  check_bit("rom.we_n", rp.we_n, 1'b1);
  check_bit("rom.bhe_n", rp.bhe_n, 1'b1);
  check_bit("rom.ble_n", rp.ble_n, 1'b1);
  check_bit("ram.we_n", mp.we_n, 1'b1);
endtask

// ---------------------------------------------------------------------------
// bounded waits, called and returning on a falling edge
// ---------------------------------------------------------------------------
task automatic wait_rdy(input string what);
  int n;
  n = 0;
  while (mcu_rdy !== 1'b1 && n < WAIT_LIMIT) begin
    @(negedge CLK2);
    n++;
  end
  if (mcu_rdy !== 1'b1) begin
    $display("timeout: mcu_rdy stayed low for %0d cycles during %s", WAIT_LIMIT, what);
    timeout_errors++;
  end
endtask

task automatic wait_oe(input logic level);
  int n;
  n = 0;
  while (snes_databus_oe_n !== level && n < WAIT_LIMIT) begin
    @(negedge CLK2);
    n++;
  end
  if (snes_databus_oe_n !== level) begin
    $display("timeout: console data bus enable never reached %0d", level);
    timeout_errors++;
  end
endtask

//--- verif/tb_snes_mem_ctrl.sv
module tb_snes_mem_ctrl;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEAD_TIMEOUT = 64;
  localparam int WAIT_LIMIT   = 200;
  localparam int RANDOM_OPS   = 48;

  // one MCU access waiting for ready to rise again
  typedef struct packed {
    logic               is_read;
    mem_pkg::mcu_addr_u addr;
    mem_pkg::byte_t     exp;
  } access_t;

  logic                                 CLK2          = 1'b0;
  logic                                 rst_n         = 1'b0;
  logic [snes_bus_pkg::SNES_ADDR_W-1:0] snes_addr_in  = '0;
  mem_pkg::byte_t                       snes_data_in  = '0;
  logic                                 snes_read_n   = 1'b1;
  logic                                 snes_write_n  = 1'b1;
  logic                                 snes_cpu_clk  = 1'b0;
  logic                                 snes_romsel_n = 1'b1;
  logic                                 mcu_rrq       = 1'b0;
  logic                                 mcu_wrq       = 1'b0;
  mem_pkg::mcu_addr_u                   mcu_addr      = '0;
  mem_pkg::byte_t                       mcu_wdata     = '0;
  logic [mem_pkg::ROM_DATA_W-1:0]       rom_rdata     = '0;
  mem_pkg::byte_t                       ram_rdata     = '0;
  mem_pkg::byte_t                       snes_data_out;
  logic                                 snes_databus_oe_n;
  logic                                 snes_databus_dir;
  logic                                 mcu_rdy;
  mem_pkg::byte_t                       mcu_rdata;
  mem_pkg::rom_port_t                   rom;
  mem_pkg::ram_port_t                   ram;

  logic           console_run = 1'b0;
  logic [3:0]     phase_cnt   = '0;
  logic           prev_rdy    = 1'b0;
  access_t        pending [$];
  logic [15:0]    psram [int];
  mem_pkg::byte_t sram [int];

  `include "tb_snes_mem_ctrl_util.svh"

  always #4 CLK2 = ~CLK2;

  snes_mem_ctrl #(
    .dead_timeout(DEAD_TIMEOUT)
  ) i_snes_mem_ctrl (
    .rst_n            (rst_n),
    .CLK2             (CLK2),
    .snes_addr_in     (snes_addr_in),
    .snes_data_in     (snes_data_in),
    .snes_read_n      (snes_read_n),
    .snes_write_n     (snes_write_n),
    .snes_cpu_clk     (snes_cpu_clk),
    .snes_romsel_n    (snes_romsel_n),
    .snes_data_out    (snes_data_out),
    .snes_databus_oe_n(snes_databus_oe_n),
    .snes_databus_dir (snes_databus_dir),
    .mcu_rrq          (mcu_rrq),
    .mcu_wrq          (mcu_wrq),
    .mcu_addr         (mcu_addr),
    .mcu_wdata        (mcu_wdata),
    .mcu_rdy          (mcu_rdy),
    .mcu_rdata        (mcu_rdata),
    .rom_rdata        (rom_rdata),
    .rom              (rom),
    .ram_rdata        (ram_rdata),
    .ram              (ram)
  );

  // ---------------------------------------------------------------------------
  // memory models
  // ---------------------------------------------------------------------------
  // PSRAM with byte lane enables
  always @(negedge CLK2) begin : psram_model
    logic [15:0] w;
    w = psram.exists(int'(rom.addr)) ? psram[int'(rom.addr)] : rom_fill(rom.addr);
    if (!rom.we_n) begin
      if (!rom.bhe_n) begin
        w[15:8] = rom.wdata[15:8];
      end
      if (!rom.ble_n) begin
        w[7:0] = rom.wdata[7:0];
      end
      psram[int'(rom.addr)] = w;
    end
    rom_rdata <= w;
  end

  always @(negedge CLK2) begin : sram_model
    mem_pkg::byte_t b;
    b = sram.exists(int'(ram.addr)) ? sram[int'(ram.addr)] : ram_fill(ram.addr);
    if (!ram.we_n) begin
      b = ram.wdata;
      sram[int'(ram.addr)] = b;
    end
    ram_rdata <= b;
  end

  // console clock with 6 cycles low and 6 high
  always @(negedge CLK2) begin
    if (!console_run) begin
      snes_cpu_clk <= 1'b0;
      phase_cnt    <= '0;
    end else if (phase_cnt == 4'd5) begin
      snes_cpu_clk <= ~snes_cpu_clk;
      phase_cnt    <= '0;
    end else begin
      phase_cnt <= phase_cnt + 1'b1;
    end
  end

  // ready rising closes the oldest access
  always @(negedge CLK2) begin : compare_reads
    access_t acc;
    if (rst_n && mcu_rdy === 1'b1 && prev_rdy === 1'b0) begin
      if (pending.size() == 0) begin
        $display("mcu_rdy rose with no MCU access outstanding at %0t", $time);
        protocol_errors++;
      end else begin
        acc = pending.pop_front();
        if (acc.is_read) begin
          check_byte($sformatf("mcu_rdata (addr %06h)", acc.addr), mcu_rdata, acc.exp);
          reads_checked++;
        end
      end
    end
    prev_rdy = mcu_rdy;
  end

  // one request pulse followed by the wait for ready
  task automatic mcu_access(input logic is_read, input logic [23:0] addr,
                            input mem_pkg::byte_t data);
    access_t acc;
    wait_rdy("request setup");
    if (mcu_rdy !== 1'b1) begin
      return;
    end
    acc.is_read = is_read;
    acc.addr    = addr;
    acc.exp     = is_read ? ref_byte(acc.addr) : data;
    if (!is_read) begin
      shadow[int'(acc.addr)] = data;
    end
    mcu_addr  = addr;
    mcu_wdata = data;
    mcu_rrq   = is_read;
    mcu_wrq   = ~is_read;
    pending.push_back(acc);
    @(negedge CLK2);
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    check_bit("mcu_rdy", mcu_rdy, 1'b0);
    if (is_read) begin
      wait_rdy("MCU read");
    end else begin
      wait_rdy("MCU write");
    end
  endtask

  // ---------------------------------------------------------------------------
  // test sequence
  // ---------------------------------------------------------------------------
  initial begin : test_sequence
    logic [31:0] r_region;
    logic [31:0] r_low;
    logic [31:0] r_read;
    logic [31:0] r_data;
    logic [23:0] addr;
    repeat (8) @(posedge CLK2);
    @(negedge CLK2);
    rst_n = 1'b1;
    @(negedge CLK2);

    check_bit("mcu_rdy", mcu_rdy, 1'b1);
    check_port_idle(rom, ram);
    check_bit("snes_databus_oe_n", snes_databus_oe_n, 1'b1);
    check_bit("snes_databus_dir", snes_databus_dir, 1'b0);

    // both lanes of one PSRAM word and its untouched neighbour
    mcu_access(1'b0, 24'h012345, 8'hA5);
    mcu_access(1'b1, 24'h012345, 8'h00);
    mcu_access(1'b1, 24'h012344, 8'h00);
    mcu_access(1'b0, 24'h012344, 8'h3C);
    mcu_access(1'b1, 24'h012345, 8'h00);
    mcu_access(1'b1, 24'h012344, 8'h00);
    mcu_access(1'b0, 24'h400000, 8'h5E);
    mcu_access(1'b1, 24'h400001, 8'h00);
    mcu_access(1'b1, 24'h400000, 8'h00);
    check_port_idle(rom, ram);

    // console runs briefly so the dead flag clears
    console_run = 1'b1;
    repeat (24) @(negedge CLK2);
    console_run = 1'b0;

    // SRAM once the stopped console clock has passed the dead timeout
    repeat (DEAD_TIMEOUT + 16) @(negedge CLK2);
    mcu_access(1'b0, 24'h880010, 8'h11);
    mcu_access(1'b0, 24'h8FFFFE, 8'hE7);
    mcu_access(1'b0, 24'h8B1235, 8'h9C);
    mcu_access(1'b1, 24'h880010, 8'h00);
    mcu_access(1'b1, 24'h8FFFFE, 8'h00);
    mcu_access(1'b1, 24'h8B1235, 8'h00);
    mcu_access(1'b1, 24'h880011, 8'h00);

    // SRAM in free slots of a running console
    console_run = 1'b1;
    mcu_access(1'b0, 24'h8D0040, 8'hC8);
    mcu_access(1'b0, 24'h8D0041, 8'h4D);
    mcu_access(1'b1, 24'h8D0040, 8'h00);
    mcu_access(1'b1, 24'h012345, 8'h00);
    mcu_access(1'b1, 24'h8D0041, 8'h00);
    check_port_idle(rom, ram);

    // console reads SRAM through the ROM area
    mcu_access(1'b0, 24'h881234, 8'h6B);
    snes_addr_in  = 24'hC01234;
    snes_romsel_n = 1'b0;
    snes_read_n   = 1'b0;
    wait_oe(1'b0);
    // address needs two more samples than romsel
    repeat (3) @(negedge CLK2);
    check_bit("snes_databus_oe_n", snes_databus_oe_n, 1'b0);
    check_bit("snes_databus_dir", snes_databus_dir, 1'b1);
    check_byte("snes_data_out", snes_data_out, ref_byte(24'h881234));
    snes_read_n   = 1'b1;
    snes_romsel_n = 1'b1;
    wait_oe(1'b1);

    // random mix over both regions
    for (int i = 0; i < RANDOM_OPS; i++) begin
      r_region = take_bits(1);
      r_low    = take_bits(5);
      r_read   = take_bits(1);
      r_data   = take_bits(8);
      addr = r_region[0] ? (24'h8C7F00 | 24'(r_low)) : (24'h213A40 | 24'(r_low));
      mcu_access(r_read[0], addr, r_data[7:0]);
    end

    repeat (4) @(negedge CLK2);
    if (pending.size() != 0) begin
      $display("%0d MCU accesses never completed", pending.size());
      protocol_errors++;
    end
    $display("errors: value %0d, timeout %0d, protocol %0d (reads checked %0d)",
             value_errors, timeout_errors, protocol_errors, reads_checked);
    if (value_errors + timeout_errors + protocol_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+verif
design/snes_bus_pkg.sv
design/mem_pkg.sv
design/snes_bus_sync.sv
design/mcu_req_router.sv
design/rom_sequencer.sv
design/ram_port_arbiter.sv
design/snes_mem_ctrl.sv
verif/tb_snes_mem_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_snes_mem_ctrl -f vlog.f -o tb_sim || exit 1
./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
[ "$status" -eq 0 ] && ! grep -q "SIMULATION FAILED" sim.log && grep -q "SIMULATION PASSED" sim.log
